//--- ad9361_rx_stream.f
source/ad9361_rx_pkg.sv
source/rx_deinterleave.sv
source/sample_packer.sv
source/axis_burst_framer.sv
source/ad9361_rx_stream_top.sv
test/ad9361_rx_stream_assertions.sv
test/ad9361_rx_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ad9361 receive stream testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ad9361_rx_stream_tb \
  -f ad9361_rx_stream.f \
  -o ad9361_rx_stream_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/ad9361_rx_stream_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1

//--- source/ad9361_rx_pkg.sv
// ad9361 receive stream definitions
`default_nettype none

package ad9361_rx_pkg;

  // raw sample and stream lane widths
  localparam int sample_width = 12;
  localparam int lane_width   = 16;
  localparam int ext_width    = lane_width - sample_width;
  localparam int num_lanes    = 8;
  localparam int tdata_width  = num_lanes * lane_width;

  // lane index of each sample, top lane first
  localparam int lane_c0a_i = 7;
  localparam int lane_c0a_q = 6;
  localparam int lane_c0b_i = 5;
  localparam int lane_c0b_q = 4;
  localparam int lane_c1a_i = 3;
  localparam int lane_c1a_q = 2;
  localparam int lane_c1b_i = 1;
  localparam int lane_c1b_q = 0;

  // burst framing, tlast on the last beat
  localparam int burst_len   = 8;
  localparam int count_width = $clog2(burst_len);

endpackage

`default_nettype wire

//--- source/ad9361_rx_stream_top.sv
// dual ad9361 receive stream
`timescale 1ns/100ps
`default_nettype none

module ad9361_rx_stream_top
  import ad9361_rx_pkg::*;
(
  input  logic                    m_axis_clk,
  input  logic                    rst,
  input  logic [sample_width-1:0] rx0_data,
  input  logic                    rx0_frame,
  input  logic [sample_width-1:0] rx1_data,
  input  logic                    rx1_frame,
  input  logic                    m_axis_tready,
  output logic                    m_axis_tvalid,
  output logic [tdata_width-1:0]  m_axis_tdata,
  output logic                    m_axis_tlast,
  output logic                    overrun
);

  // chip 0 channels
  logic                    c0a_valid;
  logic [sample_width-1:0] c0a_i;
  logic [sample_width-1:0] c0a_q;
  logic                    c0b_valid;
  logic [sample_width-1:0] c0b_i;
  logic [sample_width-1:0] c0b_q;

  // chip 1 channels
  logic                    c1a_valid;
  logic [sample_width-1:0] c1a_i;
  logic [sample_width-1:0] c1a_q;
  logic                    c1b_valid;
  logic [sample_width-1:0] c1b_i;
  logic [sample_width-1:0] c1b_q;

  logic                    word_valid;
  logic [tdata_width-1:0]  word;

  rx_deinterleave rx0_deint_i (
    .m_axis_clk (m_axis_clk),
    .rst        (rst),
    .rx_data    (rx0_data),
    .rx_frame   (rx0_frame),
    .ch_a_valid (c0a_valid),
    .ch_a_i     (c0a_i),
    .ch_a_q     (c0a_q),
    .ch_b_valid (c0b_valid),
    .ch_b_i     (c0b_i),
    .ch_b_q     (c0b_q)
  );

  rx_deinterleave rx1_deint_i (
    .m_axis_clk (m_axis_clk),
    .rst        (rst),
    .rx_data    (rx1_data),
    .rx_frame   (rx1_frame),
    .ch_a_valid (c1a_valid),
    .ch_a_i     (c1a_i),
    .ch_a_q     (c1a_q),
    .ch_b_valid (c1b_valid),
    .ch_b_i     (c1b_i),
    .ch_b_q     (c1b_q)
  );

  sample_packer packer_i (
    .m_axis_clk (m_axis_clk),
    .rst        (rst),
    .c0a_valid  (c0a_valid),
    .c0a_i      (c0a_i),
    .c0a_q      (c0a_q),
    .c0b_valid  (c0b_valid),
    .c0b_i      (c0b_i),
    .c0b_q      (c0b_q),
    .c1a_valid  (c1a_valid),
    .c1a_i      (c1a_i),
    .c1a_q      (c1a_q),
    .c1b_valid  (c1b_valid),
    .c1b_i      (c1b_i),
    .c1b_q      (c1b_q),
    .word_valid (word_valid),
    .word       (word)
  );

  axis_burst_framer framer_i (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .word_valid    (word_valid),
    .word          (word),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overrun       (overrun)
  );

endmodule

`default_nettype wire

//--- source/axis_burst_framer.sv
// axi-stream burst framer
`timescale 1ns/100ps
`default_nettype none

module axis_burst_framer
  import ad9361_rx_pkg::*;
(
  input  logic                   m_axis_clk,
  input  logic                   rst,
  input  logic                   word_valid,
  input  logic [tdata_width-1:0] word,
  input  logic                   m_axis_tready,
  output logic                   m_axis_tvalid,
  output logic [tdata_width-1:0] m_axis_tdata,
  output logic                   m_axis_tlast,
  output logic                   overrun
);

  logic                   accept;
  logic                   load;
  logic                   end_burst;
  logic [count_width-1:0] beat_count;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  assign accept = m_axis_tvalid & m_axis_tready;

  // room when empty or when the held beat leaves this cycle
  assign load = word_valid & (~m_axis_tvalid | m_axis_tready);

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      m_axis_tvalid <= 1'b0;
    end else if (load) begin
      m_axis_tvalid <= 1'b1;
    end else if (accept) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  // held word stays put under back-pressure
  always_ff @(posedge m_axis_clk) begin
    if (load) begin
      m_axis_tdata <= word;
    end
  end

  // sticky, a stalled word was already on the bus
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      overrun <= 1'b0;
    end else if (word_valid & m_axis_tvalid & ~m_axis_tready) begin
      overrun <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // burst counter
  ////////////////////////////////////////////////////////////////////////////

  assign end_burst = (beat_count == count_width'(burst_len - 1));

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      beat_count <= '0;
    end else if (accept) begin
      if (end_burst) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  // only meaningful alongside tvalid
  assign m_axis_tlast = m_axis_tvalid & end_burst;

endmodule

`default_nettype wire

//--- source/rx_deinterleave.sv
// ad9361 dual-rx sample deinterleaver
`timescale 1ns/100ps
`default_nettype none

module rx_deinterleave
  import ad9361_rx_pkg::*;
(
  input  logic                    m_axis_clk,
  input  logic                    rst,
  input  logic [sample_width-1:0] rx_data,
  input  logic                    rx_frame,
  output logic                    ch_a_valid,
  output logic [sample_width-1:0] ch_a_i,
  output logic [sample_width-1:0] ch_a_q,
  output logic                    ch_b_valid,
  output logic [sample_width-1:0] ch_b_i,
  output logic [sample_width-1:0] ch_b_q
);

  logic [sample_width-1:0] data_d;
  logic                    frame_d;
  logic [1:0]              pos;
  logic [1:0]              word_pos;
  logic [sample_width-1:0] i0_reg;
  logic [sample_width-1:0] q0_reg;
  logic [sample_width-1:0] i1_reg;
  logic                    group_valid;

  // input capture stage
  always_ff @(posedge m_axis_clk) begin
    data_d <= rx_data;
  end

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      frame_d <= 1'b0;
    end else begin
      frame_d <= rx_frame;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word position within the I0 Q0 I1 Q1 group
  ////////////////////////////////////////////////////////////////////////////

  // frame strobe restarts the group at this word
  assign word_pos = frame_d ? 2'd0 : pos;

  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      pos         <= 2'd0;
      group_valid <= 1'b0;
    end else begin
      pos         <= word_pos + 2'd1;
      group_valid <= (word_pos == 2'd3);
    end
  end

  // slot registers, Q1 releases the whole group
  always_ff @(posedge m_axis_clk) begin
    case (word_pos)
      2'd0: i0_reg <= data_d;
      2'd1: q0_reg <= data_d;
      2'd2: i1_reg <= data_d;
      default: begin
        ch_a_i <= i0_reg;
        ch_a_q <= q0_reg;
        ch_b_i <= i1_reg;
        ch_b_q <= data_d;
      end
    endcase
  end

  // both channels complete on the same word
  assign ch_a_valid = group_valid;
  assign ch_b_valid = group_valid;

endmodule

`default_nettype wire

//--- source/sample_packer.sv
// four channel sample packer
`timescale 1ns/100ps
`default_nettype none

module sample_packer
  import ad9361_rx_pkg::*;
(
  input  logic                    m_axis_clk,
  input  logic                    rst,

  // chip 0 channels
  input  logic                    c0a_valid,
  input  logic [sample_width-1:0] c0a_i,
  input  logic [sample_width-1:0] c0a_q,
  input  logic                    c0b_valid,
  input  logic [sample_width-1:0] c0b_i,
  input  logic [sample_width-1:0] c0b_q,

  // chip 1 channels
  input  logic                    c1a_valid,
  input  logic [sample_width-1:0] c1a_i,
  input  logic [sample_width-1:0] c1a_q,
  input  logic                    c1b_valid,
  input  logic [sample_width-1:0] c1b_i,
  input  logic [sample_width-1:0] c1b_q,

  output logic                    word_valid,
  output logic [tdata_width-1:0]  word
);

  logic                   all_valid;
  logic [tdata_width-1:0] next_word;

  function automatic logic [lane_width-1:0] sign_extend(
    input logic [sample_width-1:0] s
  );
    return {{ext_width{s[sample_width-1]}}, s};
  endfunction

  // partial sets are simply not used
  assign all_valid = c0a_valid & c0b_valid & c1a_valid & c1b_valid;

  ////////////////////////////////////////////////////////////////////////////
  // lane assembly
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_word = '0;
    next_word[lane_c0a_i*lane_width +: lane_width] = sign_extend(c0a_i);
    next_word[lane_c0a_q*lane_width +: lane_width] = sign_extend(c0a_q);
    next_word[lane_c0b_i*lane_width +: lane_width] = sign_extend(c0b_i);
    next_word[lane_c0b_q*lane_width +: lane_width] = sign_extend(c0b_q);
    next_word[lane_c1a_i*lane_width +: lane_width] = sign_extend(c1a_i);
    next_word[lane_c1a_q*lane_width +: lane_width] = sign_extend(c1a_q);
    next_word[lane_c1b_i*lane_width +: lane_width] = sign_extend(c1b_i);
    next_word[lane_c1b_q*lane_width +: lane_width] = sign_extend(c1b_q);
  end

  always_ff @(posedge m_axis_clk) begin
    if (all_valid) begin
      word <= next_word;
    end
  end

  // one-cycle pulse per complete set
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= all_valid;
    end
  end

endmodule

`default_nettype wire

//--- test/ad9361_rx_stream_assertions.sv
// stream handshake assertions
`timescale 1ns/100ps
`default_nettype none

module ad9361_rx_stream_assertions
  import ad9361_rx_pkg::*;
(
  input logic                   m_axis_clk,
  input logic                   rst,
  input logic                   c0a_valid,
  input logic                   c1a_valid,
  input logic                   m_axis_tready,
  input logic                   m_axis_tvalid,
  input logic [tdata_width-1:0] m_axis_tdata,
  input logic                   m_axis_tlast,
  input logic                   overrun
);

  int unsigned fail_count = 0;
  int unsigned beats_accepted;

  // accepted beats since reset
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      beats_accepted <= 0;
    end else if (m_axis_tvalid && m_axis_tready) begin
      beats_accepted <= beats_accepted + 1;
    end
  end

  // outputs clear on the clock after a reset edge
  reset_clear: assert property (@(posedge m_axis_clk)
    rst |=> !m_axis_tvalid && !m_axis_tlast && !overrun)
  else begin
    fail_count++;
    $error("stream outputs not clear after reset");
  end

  // tvalid two clocks after the channel valids when the framer has room
  q1_latency: assert property (@(posedge m_axis_clk) disable iff (rst)
    $past(c0a_valid && c1a_valid) && (!m_axis_tvalid || m_axis_tready) |=> m_axis_tvalid)
  else begin
    fail_count++;
    $error("tvalid late after both Q1 words");
  end

  hold_under_stall: assert property (@(posedge m_axis_clk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
  else begin
    fail_count++;
    $error("beat changed while stalled");
  end

  // tlast only with tvalid and only on the last beat of each burst
  tlast_rule: assert property (@(posedge m_axis_clk) disable iff (rst)
    m_axis_tlast == (m_axis_tvalid && (beats_accepted % burst_len == burst_len - 1)))
  else begin
    fail_count++;
    $error("tlast off the last beat of a burst");
  end

endmodule

bind ad9361_rx_stream_top ad9361_rx_stream_assertions assert_i (
  .m_axis_clk    (m_axis_clk),
  .rst           (rst),
  .c0a_valid     (c0a_valid),
  .c1a_valid     (c1a_valid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast),
  .overrun       (overrun)
);

`default_nettype wire

//--- test/ad9361_rx_stream_tb.sv
// dual ad9361 receive stream testbench
`timescale 1ns/100ps
`default_nettype none

module ad9361_rx_stream_tb
  import ad9361_rx_pkg::*;
();

  logic                    m_axis_clk;
  logic                    rst;
  logic [sample_width-1:0] rx0_data;
  logic                    rx0_frame;
  logic [sample_width-1:0] rx1_data;
  logic                    rx1_frame;
  logic                    m_axis_tready;
  logic                    m_axis_tvalid;
  logic [tdata_width-1:0]  m_axis_tdata;
  logic                    m_axis_tlast;
  logic                    overrun;

  // reference model of groups, word pipeline and the held beat
  logic [31:0]             rng_state = 32'd13121;
  logic [sample_width-1:0] slots [2][4];
  logic [1:0]              slot_pos [2];
  logic [2:0]              pipe_valid;
  logic [tdata_width-1:0]  pipe_word [3];
  logic                    held_exp;
  logic                    overrun_exp;
  logic [tdata_width-1:0]  expected_q [$];
  int                      beat_num = 0;
  int                      cycle_count = 0;
  string                   test_name;

  // twice the cycles of all phases together
  int timeout_cycles = 2 * (2 + 64 + 160 + 40 + 40 + 16 + 2 + 16 + 8 + 2 + 32 + 8);

  ad9361_rx_stream_top dut_i (.*);

  initial begin
    m_axis_clk = 1'b0;
    forever #50 m_axis_clk = ~m_axis_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [lane_width-1:0] to_lane(input logic [sample_width-1:0] s);
    return lane_width'($signed(s));
  endfunction

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [tdata_width-1:0] exp,
                             input logic [tdata_width-1:0] act);
    assert (act === exp) else begin
      $display("** Error [%s] expected %0h, actual %0h", what, exp, act);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    rst = 1'b1;
    rx0_data = '0;
    rx0_frame = 1'b0;
    rx1_data = '0;
    rx1_frame = 1'b0;
    m_axis_tready = 1'b0;
    repeat (2) @(posedge m_axis_clk);
    #10;
    rst = 1'b0;
    slot_pos[0] = 2'd0;
    slot_pos[1] = 2'd0;
    pipe_valid = '0;
    held_exp = 1'b0;
    overrun_exp = 1'b0;
  endtask

  // one clock of both sample buses driven 10 ns after the edge
  task automatic drive_cycle(input logic f0, input logic f1, input logic ready);
    logic [sample_width-1:0] d [2];
    logic                    f [2];
    logic [1:0]              p;
    int                      done;
    logic                    valid_now;
    logic [tdata_width-1:0]  word_now;
    check_value({test_name, " tvalid"}, tdata_width'(held_exp), tdata_width'(m_axis_tvalid));
    check_value({test_name, " overrun"}, tdata_width'(overrun_exp), tdata_width'(overrun));
    assert (dut_i.assert_i.fail_count == 0) else begin
      $display("a bound stream assertion failed during %s", test_name);
      stop_on_failure();
    end
    rng_state = xorshift32(rng_state);
    // full-scale, zero and minus one show up now and then
    d[0] = (rng_state[31:30] == 2'd0) ?
           {rng_state[29], {(sample_width-1){rng_state[28]}}} : rng_state[11:0];
    d[1] = (rng_state[27:26] == 2'd0) ?
           {rng_state[25], {(sample_width-1){rng_state[24]}}} : rng_state[23:12];
    f[0] = f0;
    f[1] = f1;
    rx0_data = d[0];
    rx0_frame = f0;
    rx1_data = d[1];
    rx1_frame = f1;
    m_axis_tready = ready;
    done = 0;
    for (int c = 0; c < 2; c++) begin
      p = f[c] ? 2'd0 : slot_pos[c];
      slots[c][p] = d[c];
      slot_pos[c] = p + 2'd1;
      if (p == 2'd3) begin
        done++;
      end
    end
    // three clocks from the Q1 word to word_valid at the framer
    valid_now = pipe_valid[2];
    word_now = pipe_word[2];
    pipe_valid = {pipe_valid[1:0], done == 2};
    pipe_word[2] = pipe_word[1];
    pipe_word[1] = pipe_word[0];
    pipe_word[0] = {to_lane(slots[0][0]), to_lane(slots[0][1]),
                    to_lane(slots[0][2]), to_lane(slots[0][3]),
                    to_lane(slots[1][0]), to_lane(slots[1][1]),
                    to_lane(slots[1][2]), to_lane(slots[1][3])};
    if (valid_now && (!held_exp || ready)) begin
      expected_q.push_back(word_now);
      held_exp = 1'b1;
    end else begin
      if (valid_now) begin
        overrun_exp = 1'b1;
      end
      if (ready) begin
        held_exp = 1'b0;
      end
    end
    @(posedge m_axis_clk);
    #10;
  endtask

  // ready_mode 0 always ready, 1 random stalls, 2 never ready
  task automatic run_stream(input int cycles, input int ready_mode, input int chip1_offset);
    logic ready;
    for (int t = 0; t < cycles; t++) begin
      rng_state = xorshift32(rng_state);
      case (ready_mode)
        0: ready = 1'b1;
        1: ready = rng_state[0] | rng_state[1];
        default: ready = 1'b0;
      endcase
      drive_cycle(t % 4 == 0, t % 4 == chip1_offset, ready);
    end
  endtask

  // misaligned chips form no word and let the queue empty
  task automatic drain_stream();
    run_stream(8, 0, 1);
    assert (expected_q.size() == 0) else begin
      $display("%0d expected words never left the stream in %s", expected_q.size(), test_name);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // accepted beats and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge m_axis_clk) begin
    if (rst) begin
      beat_num = 0;
    end else if (m_axis_tvalid && m_axis_tready) begin
      assert (expected_q.size() > 0) else begin
        $display("a beat was accepted in %s with no word expected", test_name);
        stop_on_failure();
      end
      check_value({test_name, " tdata"}, expected_q.pop_front(), m_axis_tdata);
      check_value({test_name, " tlast"}, tdata_width'(beat_num % burst_len == burst_len - 1),
                  tdata_width'(m_axis_tlast));
      beat_num++;
    end
  end

  always @(posedge m_axis_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("run did not finish within %0d cycles", timeout_cycles);
      stop_on_failure();
    end
  end

  initial begin
    test_name = "latency and reset";
    apply_reset();
    test_name = "packing";
    run_stream(64, 0, 0);
    test_name = "back-pressure";
    run_stream(160, 1, 0);
    test_name = "overrun";
    run_stream(40, 2, 0);
    run_stream(40, 0, 0);
    // chip 1 one word late, then a mid-group strobe on both chips
    test_name = "realignment";
    run_stream(16, 0, 1);
    run_stream(2, 0, 0);
    run_stream(16, 0, 0);
    drain_stream();
    test_name = "latency and reset";
    apply_reset();
    test_name = "bursts";
    run_stream(32, 0, 0);
    drain_stream();
    if (dut_i.assert_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("a bound stream assertion failed during %s", test_name);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire
